//--- cpu_pkg.sv
`default_nettype none
// ----------------------------------------
// cpu_pkg
// widths, opcodes, instruction word union
// and decoded control struct for the core
// ----------------------------------------

package cpu_pkg;

    localparam int word_w     = 32;   // data and instruction width
    localparam int reg_addr_w = 3;    // register index width
    localparam int reg_count  = 8;    // r0..r7
    localparam int opcode_w   = 7;    // instr[31:25]
    localparam int imm_w      = 16;   // instr[15:0]

    // opcode encodings at instr[31:25]
    localparam logic [opcode_w-1:0] op_mov  = 7'b0000000;
    localparam logic [opcode_w-1:0] op_movt = 7'b0000001;
    localparam logic [opcode_w-1:0] op_clr  = 7'b0000010;
    localparam logic [opcode_w-1:0] op_set  = 7'b0000011;
    localparam logic [opcode_w-1:0] op_add  = 7'b0010001;  // immediate forms
    localparam logic [opcode_w-1:0] op_sub  = 7'b0010010;
    localparam logic [opcode_w-1:0] op_and  = 7'b0010011;
    localparam logic [opcode_w-1:0] op_or   = 7'b0010100;
    localparam logic [opcode_w-1:0] op_xor  = 7'b0010101;
    localparam logic [opcode_w-1:0] op_add2 = 7'b0110001;  // register forms
    localparam logic [opcode_w-1:0] op_sub2 = 7'b0110010;
    localparam logic [opcode_w-1:0] op_and2 = 7'b0110011;
    localparam logic [opcode_w-1:0] op_or2  = 7'b0110100;
    localparam logic [opcode_w-1:0] op_xor2 = 7'b0110101;
    localparam logic [opcode_w-1:0] op_not  = 7'b0110110;
    localparam logic [opcode_w-1:0] op_nop  = 7'b1100100;
    localparam logic [opcode_w-1:0] op_halt = 7'b1101000;

    // low three opcode bits (instr[27:25]) pick the alu function
    typedef enum logic [2:0] {
        alu_add = 3'd1,
        alu_sub = 3'd2,
        alu_and = 3'd3,
        alu_or  = 3'd4,
        alu_xor = 3'd5,
        alu_not = 3'd6
    } alu_op_t;

    // write-back source
    typedef enum logic [2:0] {
        wb_alu,
        wb_imm_low,     // mov
        wb_imm_high,    // movt
        wb_zeros,       // clr
        wb_ones         // set
    } wb_sel_t;

    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [2:0]            rsvd;
        logic [imm_w-1:0]      imm;
    } imm_fmt_t;

    typedef struct packed {
        logic [opcode_w-1:0]   opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [15:0]           rsvd;
    } reg_fmt_t;

    // one word read either as immediate or register format
    typedef union packed {
        imm_fmt_t imm_fmt;
        reg_fmt_t reg_fmt;
    } instr_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic                  use_reg_op2;  // picks rs2 value over the zero-extended imm
        alu_op_t               alu_op;
        wb_sel_t               wb_sel;
        logic                  wr_en;        // already qualified by exec_strobe
        logic                  is_halt;      // same
    } ctrl_t;

endpackage

`default_nettype wire

//--- wb_slave_port.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// wb_slave_port
// wishbone classic slave, writes carry an
// instruction, reads return a register;
// also keeps the halt state
// ----------------------------------------

module wb_slave_port (
    input  wire logic                          clk,
    input  wire logic                          arst_n,
    input  wire logic                          cyc,
    input  wire logic                          stb,
    input  wire logic                          we,
    input  wire logic [cpu_pkg::reg_addr_w-1:0] adr,
    input  wire cpu_pkg::instr_t               dat_i,
    input  wire logic                          halt_req,   // halt executed this cycle
    input  wire logic [cpu_pkg::word_w-1:0]    dbg_val,
    output logic                               ack,
    output logic [cpu_pkg::word_w-1:0]         dat_o,
    output cpu_pkg::instr_t                    instr,
    output logic                               exec_strobe,
    output logic [cpu_pkg::reg_addr_w-1:0]     dbg_addr,
    output logic                               halted
);

    typedef enum logic [1:0] {
        st_idle,
        st_execute,     // instruction in flight, rf writes at end of this cycle
        st_respond      // ack cycle
    } state_t;

    state_t state;
    logic   wr_req;
    logic   rd_req;

    assign wr_req = cyc & stb & we;
    assign rd_req = cyc & stb & ~we;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (wr_req)
                        state <= st_execute;
                    else if (rd_req)
                        state <= st_respond;   // reads skip execute
                end
                st_execute: state <= st_respond;
                st_respond: state <= st_idle;  // master drops stb or starts anew
                default:    state <= st_idle;
            endcase
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            halted <= 1'b0;
        else if (halt_req)
            halted <= 1'b1;
    end

    // bus payload capture
    always_ff @(posedge clk) begin
        if (state == st_idle && wr_req)
            instr <= dat_i;
        if (state == st_idle && rd_req)
            dat_o <= dbg_val;      // dbg_addr follows adr directly
    end

    assign ack         = (state == st_respond);
    assign exec_strobe = (state == st_execute) && !halted;  // no execution once halted
    assign dbg_addr    = adr;

endmodule

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// instr_decoder
// opcode decode into register addresses,
// operand select and write-back controls
// ----------------------------------------

module instr_decoder (
    input  wire cpu_pkg::instr_t           instr,
    input  wire logic                      exec_strobe,
    output cpu_pkg::ctrl_t                 ctrl,
    output logic [cpu_pkg::imm_w-1:0]      imm
);

    import cpu_pkg::*;

    logic [opcode_w-1:0] opcode;

    assign opcode = instr.reg_fmt.opcode;   // same bits in both formats
    assign imm    = instr.imm_fmt.imm;

    always_comb begin
        // inactive defaults, also what unknown opcodes get
        ctrl.rs1         = instr.reg_fmt.rs1;
        ctrl.rs2         = instr.reg_fmt.rs2;
        ctrl.rd          = instr.reg_fmt.rd;
        ctrl.use_reg_op2 = 1'b0;
        ctrl.alu_op      = alu_add;
        ctrl.wb_sel      = wb_alu;
        ctrl.wr_en       = 1'b0;
        ctrl.is_halt     = 1'b0;

        case (opcode)
            op_mov, op_movt: begin
                // read rd back so the untouched half is kept
                ctrl.rs1    = instr.imm_fmt.rd;
                ctrl.rd     = instr.imm_fmt.rd;
                ctrl.wb_sel = (opcode == op_mov) ? wb_imm_low : wb_imm_high;
                ctrl.wr_en  = exec_strobe;
            end
            op_add, op_sub, op_and, op_or, op_xor: begin
                ctrl.rs1         = instr.imm_fmt.rs1;
                ctrl.rd          = instr.imm_fmt.rd;
                ctrl.use_reg_op2 = 1'b0;                     // op2 = imm
                ctrl.alu_op      = alu_op_t'(opcode[2:0]);   // instr[27:25]
                ctrl.wb_sel      = wb_alu;
                ctrl.wr_en       = exec_strobe;
            end
            op_add2, op_sub2, op_and2, op_or2, op_xor2, op_not: begin
                ctrl.rs1         = instr.reg_fmt.rs1;
                ctrl.rs2         = instr.reg_fmt.rs2;        // ignored by not
                ctrl.rd          = instr.reg_fmt.rd;
                ctrl.use_reg_op2 = 1'b1;
                ctrl.alu_op      = alu_op_t'(opcode[2:0]);
                ctrl.wb_sel      = wb_alu;
                ctrl.wr_en       = exec_strobe;
            end
            op_clr: begin
                ctrl.rd     = instr.imm_fmt.rd;
                ctrl.wb_sel = wb_zeros;
                ctrl.wr_en  = exec_strobe;
            end
            op_set: begin
                ctrl.rd     = instr.imm_fmt.rd;
                ctrl.wb_sel = wb_ones;
                ctrl.wr_en  = exec_strobe;
            end
            op_nop: begin
                ctrl.wr_en = 1'b0;     // acknowledged, nothing else
            end
            op_halt: begin
                ctrl.is_halt = exec_strobe;  // port latches halted
            end
            default: begin
                // dropped or unknown opcodes, no effect
                ctrl.wr_en   = 1'b0;
                ctrl.is_halt = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// reg_file
// eight 32-bit registers, two operand
// reads, one debug read, one write
// ----------------------------------------

module reg_file (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire cpu_pkg::ctrl_t                 ctrl,
    input  wire logic [cpu_pkg::word_w-1:0]     wr_data,
    input  wire logic [cpu_pkg::reg_addr_w-1:0] dbg_addr,
    output logic [cpu_pkg::word_w-1:0]          rs1_val,
    output logic [cpu_pkg::word_w-1:0]          rs2_val,
    output logic [cpu_pkg::word_w-1:0]          dbg_val
);

    import cpu_pkg::*;

    logic [word_w-1:0] regs [reg_count];

    // all registers read zero after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end else if (ctrl.wr_en) begin
            regs[ctrl.rd] <= wr_data;
        end
    end

    // combinational reads, old value until the write edge
    assign rs1_val = regs[ctrl.rs1];
    assign rs2_val = regs[ctrl.rs2];
    assign dbg_val = regs[dbg_addr];   // bus read path

endmodule

`default_nettype wire

//--- exec_unit.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// exec_unit
// operand select, alu, and merge of the
// write-back source into wr_data
// ----------------------------------------

module exec_unit (
    input  wire cpu_pkg::ctrl_t               ctrl,
    input  wire logic [cpu_pkg::imm_w-1:0]    imm,
    input  wire logic [cpu_pkg::word_w-1:0]   rs1_val,
    input  wire logic [cpu_pkg::word_w-1:0]   rs2_val,
    output logic [cpu_pkg::word_w-1:0]        wr_data
);

    import cpu_pkg::*;

    logic [word_w-1:0] imm_ext;
    logic [word_w-1:0] op2;
    logic [word_w-1:0] alu_result;

    assign imm_ext = {{(word_w-imm_w){1'b0}}, imm};    // zero extend, no sign
    assign op2     = ctrl.use_reg_op2 ? rs2_val : imm_ext;

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_result = rs1_val + op2;
            alu_sub: alu_result = rs1_val - op2;  // wraps at 32 bits
            alu_and: alu_result = rs1_val & op2;
            alu_or:  alu_result = rs1_val | op2;
            alu_xor: alu_result = rs1_val ^ op2;
            alu_not: alu_result = ~rs1_val;       // op2 unused
            default: alu_result = '0;
        endcase
    end

    // rs1 carries rd for mov/movt, so the kept half is the old value
    always_comb begin
        case (ctrl.wb_sel)
            wb_alu:      wr_data = alu_result;
            wb_imm_low:  wr_data = {rs1_val[word_w-1:imm_w], imm};
            wb_imm_high: wr_data = {imm, rs1_val[imm_w-1:0]};
            wb_zeros:    wr_data = '0;
            wb_ones:     wr_data = '1;
            default:     wr_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

//--- mini_core.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// mini_core
// single-cycle register machine behind a
// wishbone classic slave port
// ----------------------------------------

module mini_core (
    input  wire logic                           clk,
    input  wire logic                           arst_n,
    input  wire logic                           cyc,
    input  wire logic                           stb,
    input  wire logic                           we,
    input  wire logic [cpu_pkg::reg_addr_w-1:0] adr,
    input  wire logic [cpu_pkg::word_w-1:0]     dat_i,
    output logic                                ack,
    output logic [cpu_pkg::word_w-1:0]          dat_o,
    output logic                                halted
);

    import cpu_pkg::*;

    instr_t                instr;        // registered instruction
    logic                  exec_strobe;
    logic [reg_addr_w-1:0] dbg_addr;
    logic [word_w-1:0]     dbg_val;
    ctrl_t                 ctrl;
    logic [imm_w-1:0]      imm;
    logic [word_w-1:0]     rs1_val;
    logic [word_w-1:0]     rs2_val;
    logic [word_w-1:0]     wr_data;

    wb_slave_port u_port (
        .clk         (clk),
        .arst_n      (arst_n),
        .cyc         (cyc),
        .stb         (stb),
        .we          (we),
        .adr         (adr),
        .dat_i       (dat_i),         // bus word taken as instruction
        .halt_req    (ctrl.is_halt),
        .dbg_val     (dbg_val),
        .ack         (ack),
        .dat_o       (dat_o),
        .instr       (instr),
        .exec_strobe (exec_strobe),
        .dbg_addr    (dbg_addr),
        .halted      (halted)
    );

    instr_decoder u_dec (
        .instr       (instr),
        .exec_strobe (exec_strobe),
        .ctrl        (ctrl),
        .imm         (imm)
    );

    reg_file u_rf (
        .clk      (clk),
        .arst_n   (arst_n),
        .ctrl     (ctrl),
        .wr_data  (wr_data),
        .dbg_addr (dbg_addr),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .dbg_val  (dbg_val)
    );

    exec_unit u_exec (
        .ctrl    (ctrl),
        .imm     (imm),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .wr_data (wr_data)
    );

endmodule

`default_nettype wire

//--- mini_core_sva.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// mini_core_sva
// wishbone handshake and halt rules,
// bound into the core
// ----------------------------------------

module mini_core_sva (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic cyc,
    input wire logic stb,
    input wire logic ack,
    input wire logic halted,
    input wire logic wr_en    // rf write enable from the decoder
);

    ack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        ack |-> (cyc && stb))
        else $error("ack outside an active bus cycle");

    // single-cycle ack
    ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        ack |=> !ack)
        else $error("ack high for two cycles");

    ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !ack)
        else $error("ack high during reset");

    no_write_halted: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !wr_en)
        else $error("register write while halted");

endmodule

bind mini_core mini_core_sva u_sva (
    .clk    (clk),
    .arst_n (arst_n),
    .cyc    (cyc),
    .stb    (stb),
    .ack    (ack),
    .halted (halted),
    .wr_en  (ctrl.wr_en)
);

`default_nettype wire

//--- tb_mini_core.sv
`timescale 1ns/1ps
`default_nettype none
// ----------------------------------------
// tb_mini_core
// replays the vector file as wishbone
// cycles and checks register and halt state
// ----------------------------------------

module tb_mini_core;

    import cpu_pkg::*;

    localparam int clk_half      = 4;      // 8 ns period
    localparam int drive_delay   = 1;      // inputs move 1 ns after the edge
    localparam int ack_timeout   = 20;     // cycles
    localparam int reset_cycles  = 8;
    localparam int vec_depth     = 240;    // three words per vector line
    localparam int write_latency = 2;      // edges from write request to ack
    localparam int read_latency  = 1;      // edges from read request to ack

    typedef struct packed {
        logic [31:0] kind;    // 1 write, 2 read, 3 halted, 0 end
        logic [31:0] adr;
        logic [31:0] data;    // instruction or expected value
    } vec_op_t;

    logic                  clk;
    logic                  arst_n;
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [reg_addr_w-1:0] adr;
    logic [word_w-1:0]     dat_i;
    logic                  ack;
    logic [word_w-1:0]     dat_o;
    logic                  halted;

    logic [31:0] vec_mem [vec_depth];

    mini_core uut (
        .clk    (clk),
        .arst_n (arst_n),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .dat_i  (dat_i),
        .ack    (ack),
        .dat_o  (dat_o),
        .halted (halted)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // one rising edge, then the drive offset
    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    // counts the edges from the request until ack is seen
    task automatic wait_for_ack(input string what, output int edges);
        edges = 1;
        next_cycle();
        while (!ack) begin
            if (edges >= ack_timeout) begin
                $display("no ack within %0d cycles on %s", ack_timeout, what);
                stop_with_failure();
            end
            edges++;
            next_cycle();
        end
    endtask

    // master holds the request through the ack edge and drops it after
    task automatic end_cycle();
        next_cycle();
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic bus_write(input logic [word_w-1:0] word);
        int edges;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = 1'b1;
        adr   = '0;
        dat_i = word;
        wait_for_ack($sformatf("write of instruction 0x%08h", word), edges);
        check_value("ack latency of write", edges, write_latency);
        end_cycle();
    endtask

    task automatic bus_read(input logic [reg_addr_w-1:0] idx, output logic [word_w-1:0] val);
        int edges;
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = idx;
        wait_for_ack($sformatf("read of r%0d", idx), edges);
        check_value("ack latency of read", edges, read_latency);
        val = dat_o;              // held through the ack cycle
        end_cycle();
    endtask

    task automatic idle_gap();
        int gap;
        gap = int'($urandom % 4);   // 0..3 idle cycles
        repeat (gap) next_cycle();
    endtask

    initial begin
        vec_op_t           op;
        logic [word_w-1:0] rd_val;
        int                idx;
        int                n_ops;

        arst_n = 1'b0;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_i  = '0;
        rd_val = '0;
        void'($urandom(13531));
        $readmemh("mini_core_vectors.txt", vec_mem);

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        arst_n = 1'b1;
        next_cycle();

        idx   = 0;
        n_ops = 0;
        while (idx + 2 < vec_depth && vec_mem[idx] != 32'd0) begin
            op.kind = vec_mem[idx];
            op.adr  = vec_mem[idx + 1];
            op.data = vec_mem[idx + 2];
            case (op.kind)
                32'd1: bus_write(op.data);
                32'd2: begin
                    bus_read(op.adr[reg_addr_w-1:0], rd_val);
                    check_value($sformatf("dat_o (r%0d)", op.adr), rd_val, op.data);
                end
                32'd3: check_value("halted", {31'b0, halted}, op.data);
                default: begin
                    $display("unknown operation %0h on vector line %0d", op.kind, idx / 3);
                    stop_with_failure();
                end
            endcase
            idle_gap();
            n_ops++;
            idx += 3;
        end

        if (n_ops == 0) begin
            $display("no operations found in the vector file");
            stop_with_failure();
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- mini_core_vectors.txt
// kind adr data: 1 = write instruction in data, 2 = read register adr and expect data,
// 3 = expect halted equal to data, 0 = end of list
2 0 00000000
2 1 00000000
2 2 00000000
2 3 00000000
2 4 00000000
2 5 00000000
2 6 00000000
2 7 00000000
1 0 00405678 // mov  r1, 0x5678
1 0 02401234 // movt r1, 0x1234
2 1 12345678
1 0 06800000 // set  r2
2 2 ffffffff
1 0 04800000 // clr  r2
2 2 00000000
1 0 22c88000 // add  r3, r1, 0x8000
1 0 25000001 // sub  r4, r0, 1
1 0 2748ff0f // and  r5, r1, 0xff0f
1 0 29888001 // or   r6, r1, 0x8001
1 0 2be0ffff // xor  r7, r4, 0xffff
2 3 1234d678
2 4 ffffffff
2 5 00005608
2 6 1234d679
2 7 ffff0000
1 0 628b0000 // add2 r2, r1, r3
1 0 64d90000 // sub2 r3, r3, r1
1 0 67770000 // and2 r5, r6, r7
1 0 699d0000 // or2  r6, r3, r5
1 0 6bf90000 // xor2 r7, r7, r1
1 0 6d080000 // not  r4, r1
2 2 24692cf0
2 3 00008000
2 5 12340000
2 6 12348000
2 7 edcb5678
2 4 edcba987
1 0 c8401111 // nop
1 0 40480004 // load, dropped
2 1 12345678
2 2 24692cf0
3 0 00000000
1 0 d0000000 // halt
3 0 00000001
1 0 0040aaaa // mov  r1, 0xaaaa while halted
2 1 12345678
3 0 00000001
0 0 00000000

//--- build.f
cpu_pkg.sv
wb_slave_port.sv
instr_decoder.sv
reg_file.sv
exec_unit.sv
mini_core.sv
mini_core_sva.sv
tb_mini_core.sv

//--- run.sh
#!/bin/sh
# compile and run the mini_core testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mini_core -f build.f -o sim_mini_core
./obj_dir/sim_mini_core > sim.log 2>&1 || true
cat sim.log
if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
